/* source/mp_pkg.sv */
package mp_pkg;

  localparam int def_width    = 32;
  localparam int def_num_bank = 8;
  localparam int def_bit_bank = 3;
  localparam int def_bit_row  = 6;   // 64 rows per bank.
  localparam int def_rd_delay = 2;   // Banks and tables share one latency.

  // Map entry is {valid, bank}.
  function automatic int map_w(input int bit_bank);
    return bit_bank + 1;
  endfunction

endpackage

/* source/bank_if.sv */
`timescale 1ns/1ps

interface bank_if import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int num_bank = def_num_bank,
  parameter int bit_row  = def_bit_row
) ();

  logic [num_bank-1:0]              write_a;  // One write strobe per bank.
  logic [num_bank-1:0][bit_row-1:0] addr_a;
  logic [num_bank-1:0][width-1:0]   din_a;

  logic [num_bank-1:0]              read_b;
  logic [num_bank-1:0][bit_row-1:0] addr_b;
  logic [num_bank-1:0][width-1:0]   dout_b;

  logic [num_bank-1:0]              read_c;
  logic [num_bank-1:0][bit_row-1:0] addr_c;
  logic [num_bank-1:0][width-1:0]   dout_c;

  modport mux (
    output write_a, addr_a, din_a,
    output read_b, addr_b,
    output read_c, addr_c,
    input  dout_b, dout_c
  );

  modport array (
    input  write_a, addr_a, din_a,
    input  read_b, addr_b,
    input  read_c, addr_c,
    output dout_b, dout_c
  );

endinterface

/* source/table_if.sv */
`timescale 1ns/1ps

interface table_if import mp_pkg::*; #(
  parameter int dw      = def_width,
  parameter int bit_row = def_bit_row
) ();

  logic [1:0]              write;   // Index is the copy.
  logic [1:0][bit_row-1:0] waddr;
  logic [1:0][dw-1:0]      din;

  logic                    read1;
  logic [bit_row-1:0]      raddr1;
  logic [dw-1:0]           dout1;

  logic                    read2;
  logic [bit_row-1:0]      raddr2;
  logic [dw-1:0]           dout2;

  modport mux (
    output write, waddr, din,
    output read1, raddr1, read2, raddr2,
    input  dout1, dout2
  );

  modport tbl (
    input  write, waddr, din,
    input  read1, raddr1, read2, raddr2,
    output dout1, dout2
  );

endinterface

/* source/mp_port_mux.sv */
`timescale 1ns/1ps

module mp_port_mux import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int num_bank = def_num_bank,
  parameter int bit_bank = def_bit_bank,
  parameter int bit_row  = def_bit_row,
  parameter int rd_delay = def_rd_delay
) (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         pread1,
  input  logic [bit_bank-1:0]          prdbadr1,
  input  logic [bit_row-1:0]           prdradr1,
  output logic [width-1:0]             pdout1,
  input  logic                         pread2,
  input  logic [bit_bank-1:0]          prdbadr2,
  input  logic [bit_row-1:0]           prdradr2,
  output logic [width-1:0]             pdout2,

  input  logic                         pwrite1,
  input  logic [bit_bank-1:0]          pwrbadr1,
  input  logic [bit_row-1:0]           pwrradr1,
  input  logic [width-1:0]             pdin1,
  input  logic                         pwrite2,
  input  logic [bit_bank-1:0]          pwrbadr2,
  input  logic [bit_row-1:0]           pwrradr2,
  input  logic [width-1:0]             pdin2,

  input  logic                         sread1,
  input  logic [bit_row-1:0]           srdradr1,
  output logic [map_w(bit_bank)-1:0]   sdout1,
  input  logic                         sread2,
  input  logic [bit_row-1:0]           srdradr2,
  output logic [map_w(bit_bank)-1:0]   sdout2,
  input  logic                         swrite,
  input  logic [bit_row-1:0]           swrradr,
  input  logic [map_w(bit_bank)-1:0]   sdin,

  input  logic                         cread1,
  input  logic [bit_row-1:0]           crdradr1,
  output logic [width-1:0]             cdout1,
  input  logic                         cread2,
  input  logic [bit_row-1:0]           crdradr2,
  output logic [width-1:0]             cdout2,
  input  logic                         cwrite,
  input  logic [bit_row-1:0]           cwrradr,
  input  logic [width-1:0]             cdin,

  bank_if.mux                          bk,
  table_if.mux                         mp,
  table_if.mux                         ch
);

  logic [bit_bank-1:0] bsel1 [rd_delay];  // Bank of each read in flight.
  logic [bit_bank-1:0] bsel2 [rd_delay];

  for (genvar b = 0; b < num_bank; b++) begin : g_bank
    localparam logic [bit_bank-1:0] bid = bit_bank'(b);
    logic hit2;

    assign hit2 = pwrite2 && (pwrbadr2 == bid);

    assign bk.write_a[b] = (pwrite1 && (pwrbadr1 == bid)) || hit2;
    assign bk.addr_a[b]  = hit2 ? pwrradr2 : pwrradr1;
    assign bk.din_a[b]   = hit2 ? pdin2 : pdin1;

    assign bk.read_b[b]  = pread1 && (prdbadr1 == bid);
    assign bk.addr_b[b]  = prdradr1;  // Rows go to every bank.
    assign bk.read_c[b]  = pread2 && (prdbadr2 == bid);
    assign bk.addr_c[b]  = prdradr2;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rd_delay; i++) begin
        bsel1[i] <= '0;
        bsel2[i] <= '0;
      end
    end else begin
      bsel1[0] <= prdbadr1;
      bsel2[0] <= prdbadr2;
      for (int i = 1; i < rd_delay; i++) begin
        bsel1[i] <= bsel1[i-1];
        bsel2[i] <= bsel2[i-1];
      end
    end
  end

  assign pdout1 = bk.dout_b[bsel1[rd_delay-1]];
  assign pdout2 = bk.dout_c[bsel2[rd_delay-1]];

  // Both copies take every write.
  assign mp.write  = {2{swrite}};
  assign mp.waddr  = {2{swrradr}};
  assign mp.din    = {2{sdin}};
  assign mp.read1  = sread1;
  assign mp.raddr1 = srdradr1;
  assign mp.read2  = sread2;
  assign mp.raddr2 = srdradr2;
  assign sdout1    = mp.dout1;
  assign sdout2    = mp.dout2;

  assign ch.write  = {2{cwrite}};
  assign ch.waddr  = {2{cwrradr}};
  assign ch.din    = {2{cdin}};
  assign ch.read1  = cread1;
  assign ch.raddr1 = crdradr1;
  assign ch.read2  = cread2;
  assign ch.raddr2 = crdradr2;
  assign cdout1    = ch.dout1;
  assign cdout2    = ch.dout2;

endmodule

/* source/mp_ctrl.sv */
`timescale 1ns/1ps

module mp_ctrl import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int bit_bank = def_bit_bank,
  parameter int bit_row  = def_bit_row,
  parameter int rd_delay = def_rd_delay
) (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         rd1,
  input  logic [bit_bank-1:0]          rd_bank1,
  input  logic [bit_row-1:0]           rd_row1,
  input  logic                         rd2,
  input  logic [bit_bank-1:0]          rd_bank2,
  input  logic [bit_row-1:0]           rd_row2,
  input  logic                         wr1,
  input  logic [bit_bank-1:0]          wr_bank1,
  input  logic [bit_row-1:0]           wr_row1,
  input  logic [width-1:0]             wdata1,
  input  logic                         wr2,
  input  logic [bit_bank-1:0]          wr_bank2,
  input  logic [bit_row-1:0]           wr_row2,
  input  logic [width-1:0]             wdata2,
  output logic [width-1:0]             rdata1,
  output logic                         rvalid1,
  output logic [width-1:0]             rdata2,
  output logic                         rvalid2,

  output logic                         pread1,
  output logic [bit_bank-1:0]          prdbadr1,
  output logic [bit_row-1:0]           prdradr1,
  input  logic [width-1:0]             pdout1,
  output logic                         pread2,
  output logic [bit_bank-1:0]          prdbadr2,
  output logic [bit_row-1:0]           prdradr2,
  input  logic [width-1:0]             pdout2,
  output logic                         pwrite1,
  output logic [bit_bank-1:0]          pwrbadr1,
  output logic [bit_row-1:0]           pwrradr1,
  output logic [width-1:0]             pdin1,
  output logic                         pwrite2,
  output logic [bit_bank-1:0]          pwrbadr2,
  output logic [bit_row-1:0]           pwrradr2,
  output logic [width-1:0]             pdin2,

  output logic                         sread1,
  output logic [bit_row-1:0]           srdradr1,
  input  logic [map_w(bit_bank)-1:0]   sdout1,
  output logic                         sread2,
  output logic [bit_row-1:0]           srdradr2,
  input  logic [map_w(bit_bank)-1:0]   sdout2,
  output logic                         swrite,
  output logic [bit_row-1:0]           swrradr,
  output logic [map_w(bit_bank)-1:0]   sdin,

  output logic                         cread1,
  output logic [bit_row-1:0]           crdradr1,
  input  logic [width-1:0]             cdout1,
  output logic                         cread2,
  output logic [bit_row-1:0]           crdradr2,
  input  logic [width-1:0]             cdout2,
  output logic                         cwrite,
  output logic [bit_row-1:0]           cwrradr,
  output logic [width-1:0]             cdin
);

  localparam int map_width = map_w(bit_bank);

  logic                collide;
  logic                vld1 [rd_delay];
  logic                vld2 [rd_delay];
  logic [bit_bank-1:0] bnk1 [rd_delay];
  logic [bit_bank-1:0] bnk2 [rd_delay];
  logic                hit1;
  logic                hit2;

  assign collide = wr1 && wr2 && (wr_bank1 == wr_bank2);

  // Reads look up bank, map and cache in parallel.
  assign pread1   = rd1;
  assign prdbadr1 = rd_bank1;
  assign prdradr1 = rd_row1;
  assign pread2   = rd2;
  assign prdbadr2 = rd_bank2;
  assign prdradr2 = rd_row2;
  assign sread1   = rd1;
  assign srdradr1 = rd_row1;
  assign sread2   = rd2;
  assign srdradr2 = rd_row2;
  assign cread1   = rd1;
  assign crdradr1 = rd_row1;
  assign cread2   = rd2;
  assign crdradr2 = rd_row2;

  assign pwrite1  = wr1;
  assign pwrbadr1 = wr_bank1;
  assign pwrradr1 = wr_row1;
  assign pdin1    = wdata1;
  assign pwrite2  = wr2 && !collide;  // Displaced to the cache on a collision.
  assign pwrbadr2 = wr_bank2;
  assign pwrradr2 = wr_row2;
  assign pdin2    = wdata2;

  assign cwrite   = collide;
  assign cwrradr  = wr_row2;
  assign cdin     = wdata2;
  assign swrite   = collide;
  assign swrradr  = wr_row2;
  assign sdin     = {1'b1, wr_bank2};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rd_delay; i++) begin
        vld1[i] <= 1'b0;
        vld2[i] <= 1'b0;
        bnk1[i] <= '0;
        bnk2[i] <= '0;
      end
    end else begin
      vld1[0] <= rd1;
      vld2[0] <= rd2;
      bnk1[0] <= rd_bank1;
      bnk2[0] <= rd_bank2;
      for (int i = 1; i < rd_delay; i++) begin
        vld1[i] <= vld1[i-1];
        vld2[i] <= vld2[i-1];
        bnk1[i] <= bnk1[i-1];
        bnk2[i] <= bnk2[i-1];
      end
    end
  end

  assign hit1 = sdout1[map_width-1] && (sdout1[bit_bank-1:0] == bnk1[rd_delay-1]);
  assign hit2 = sdout2[map_width-1] && (sdout2[bit_bank-1:0] == bnk2[rd_delay-1]);

  assign rdata1  = hit1 ? cdout1 : pdout1;
  assign rdata2  = hit2 ? cdout2 : pdout2;
  assign rvalid1 = vld1[rd_delay-1];
  assign rvalid2 = vld2[rd_delay-1];

endmodule

/* source/bank_array.sv */
`timescale 1ns/1ps

module bank_array import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int num_bank = def_num_bank,
  parameter int bit_row  = def_bit_row,
  parameter int rd_delay = def_rd_delay
) (
  input logic   clk,
  bank_if.array bk
);

  localparam int depth = 1 << bit_row;

  for (genvar b = 0; b < num_bank; b++) begin : g_bank
    logic [width-1:0] mem    [depth];
    logic [width-1:0] pipe_b [rd_delay];
    logic [width-1:0] pipe_c [rd_delay];

    always_ff @(posedge clk) begin
      if (bk.write_a[b]) begin
        mem[bk.addr_a[b]] <= bk.din_a[b];
      end
    end

    // First stage samples before the write lands, so reads see the old word.
    always_ff @(posedge clk) begin
      if (bk.read_b[b]) begin
        pipe_b[0] <= mem[bk.addr_b[b]];
      end
      if (bk.read_c[b]) begin
        pipe_c[0] <= mem[bk.addr_c[b]];
      end
      for (int i = 1; i < rd_delay; i++) begin
        pipe_b[i] <= pipe_b[i-1];
        pipe_c[i] <= pipe_c[i-1];
      end
    end

    assign bk.dout_b[b] = pipe_b[rd_delay-1];
    assign bk.dout_c[b] = pipe_c[rd_delay-1];
  end

endmodule

/* source/dual_table.sv */
`timescale 1ns/1ps

module dual_table import mp_pkg::*; #(
  parameter int dw             = def_width,
  parameter int bit_row        = def_bit_row,
  parameter int rd_delay       = def_rd_delay,
  parameter bit clear_on_reset = 1'b0
) (
  input logic  clk,
  input logic  rst_n,
  table_if.tbl tb
);

  localparam int depth = 1 << bit_row;

  logic [1:0]              rd;
  logic [1:0][bit_row-1:0] raddr;
  logic [1:0][dw-1:0]      rdata;

  assign rd       = {tb.read2, tb.read1};  // Copy 0 serves port 1.
  assign raddr    = {tb.raddr2, tb.raddr1};
  assign tb.dout1 = rdata[0];
  assign tb.dout2 = rdata[1];

  for (genvar c = 0; c < 2; c++) begin : g_copy
    logic [dw-1:0] mem  [depth];
    logic [dw-1:0] pipe [rd_delay];

    if (clear_on_reset) begin : g_clr
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;  // Map entries start invalid.
          end
        end else if (tb.write[c]) begin
          mem[tb.waddr[c]] <= tb.din[c];
        end
      end
    end else begin : g_keep
      always_ff @(posedge clk) begin
        if (tb.write[c]) begin
          mem[tb.waddr[c]] <= tb.din[c];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (rd[c]) begin
        pipe[0] <= mem[raddr[c]];
      end
      for (int i = 1; i < rd_delay; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end

    assign rdata[c] = pipe[rd_delay-1];
  end

endmodule

/* source/mp_top.sv */
`timescale 1ns/1ps

module mp_top import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int num_bank = def_num_bank,
  parameter int bit_bank = def_bit_bank,
  parameter int bit_row  = def_bit_row,
  parameter int rd_delay = def_rd_delay
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rd1,
  input  logic [bit_bank-1:0] rd_bank1,
  input  logic [bit_row-1:0]  rd_row1,
  input  logic                rd2,
  input  logic [bit_bank-1:0] rd_bank2,
  input  logic [bit_row-1:0]  rd_row2,
  input  logic                wr1,
  input  logic [bit_bank-1:0] wr_bank1,
  input  logic [bit_row-1:0]  wr_row1,
  input  logic [width-1:0]    wdata1,
  input  logic                wr2,
  input  logic [bit_bank-1:0] wr_bank2,
  input  logic [bit_row-1:0]  wr_row2,
  input  logic [width-1:0]    wdata2,
  output logic [width-1:0]    rdata1,
  output logic                rvalid1,
  output logic [width-1:0]    rdata2,
  output logic                rvalid2
);

  localparam int map_width = map_w(bit_bank);

  // Logical ports between controller and mux.
  logic                 pread1, pread2, pwrite1, pwrite2;
  logic [bit_bank-1:0]  prdbadr1, prdbadr2, pwrbadr1, pwrbadr2;
  logic [bit_row-1:0]   prdradr1, prdradr2, pwrradr1, pwrradr2;
  logic [width-1:0]     pdout1, pdout2, pdin1, pdin2;
  logic                 sread1, sread2, swrite;
  logic [bit_row-1:0]   srdradr1, srdradr2, swrradr;
  logic [map_width-1:0] sdout1, sdout2, sdin;
  logic                 cread1, cread2, cwrite;
  logic [bit_row-1:0]   crdradr1, crdradr2, cwrradr;
  logic [width-1:0]     cdout1, cdout2, cdin;

  bank_if  #(.width(width), .num_bank(num_bank), .bit_row(bit_row)) bk_bus ();
  table_if #(.dw(map_width), .bit_row(bit_row)) map_bus ();
  table_if #(.dw(width), .bit_row(bit_row)) cache_bus ();

  mp_ctrl #(
    .width(width), .bit_bank(bit_bank), .bit_row(bit_row), .rd_delay(rd_delay)
  ) u_ctrl (.*);

  mp_port_mux #(
    .width(width), .num_bank(num_bank), .bit_bank(bit_bank),
    .bit_row(bit_row), .rd_delay(rd_delay)
  ) u_mux (
    .bk(bk_bus),
    .mp(map_bus),
    .ch(cache_bus),
    .*
  );

  bank_array #(
    .width(width), .num_bank(num_bank), .bit_row(bit_row), .rd_delay(rd_delay)
  ) u_banks (
    .clk(clk),
    .bk(bk_bus)
  );

  dual_table #(
    .dw(map_width), .bit_row(bit_row), .rd_delay(rd_delay), .clear_on_reset(1'b1)
  ) u_map (
    .clk(clk),
    .rst_n(rst_n),
    .tb(map_bus)
  );

  dual_table #(
    .dw(width), .bit_row(bit_row), .rd_delay(rd_delay), .clear_on_reset(1'b0)
  ) u_cache (
    .clk(clk),
    .rst_n(rst_n),
    .tb(cache_bus)
  );

endmodule

/* tests/mp_checker.sv */
`timescale 1ns/1ps

module mp_checker import mp_pkg::*; #(
  parameter int width    = def_width,
  parameter int num_bank = def_num_bank,
  parameter int bit_bank = def_bit_bank,
  parameter int bit_row  = def_bit_row,
  parameter int rd_delay = def_rd_delay
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rd1,
  input  logic [bit_bank-1:0] rd_bank1,
  input  logic [bit_row-1:0]  rd_row1,
  input  logic                rd2,
  input  logic [bit_bank-1:0] rd_bank2,
  input  logic [bit_row-1:0]  rd_row2,
  input  logic                wr1,
  input  logic [bit_bank-1:0] wr_bank1,
  input  logic [bit_row-1:0]  wr_row1,
  input  logic [width-1:0]    wdata1,
  input  logic                wr2,
  input  logic [bit_bank-1:0] wr_bank2,
  input  logic [bit_row-1:0]  wr_row2,
  input  logic [width-1:0]    wdata2,
  input  logic [width-1:0]    rdata1,
  input  logic                rvalid1,
  input  logic [width-1:0]    rdata2,
  input  logic                rvalid2,
  input  int                  entry,
  output logic                finished,
  output int                  errors
);

  localparam int depth = 1 << bit_row;

  logic [width-1:0] ref_mem [num_bank][depth];
  bit               written [num_bank][depth];
  logic             pend_v  [2][rd_delay];  // Reads in flight per port.
  logic [width-1:0] pend_d  [2][rd_delay];
  bit               pend_k  [2][rd_delay];
  int               pend_t  [rd_delay];
  int               last_tag    = -1;
  int               test_errs   = 0;
  int               test_checks = 0;
  int               checks      = 0;
  int               tests_done  = 0;
  int               err_count   = 0;
  int               reset_errs  = 0;
  bit               done_flag   = 1'b0;

  assign errors   = err_count + reset_errs;
  assign finished = done_flag;

  task automatic note_error();
    err_count = err_count + 1;
    test_errs = test_errs + 1;
  endtask

  task automatic check_port(input int p, input logic v, input logic [width-1:0] d);
    string name;
    name = (p == 0) ? "rdata1" : "rdata2";
    if (pend_v[p][rd_delay-1]) begin
      test_checks = test_checks + 1;
      checks      = checks + 1;
      if (v !== 1'b1) begin
        $display("Read on port %0d got no rvalid pulse", p + 1);
        note_error();
      end else if (pend_k[p][rd_delay-1] && (d !== pend_d[p][rd_delay-1])) begin
        $display("Mismatch %s: expected %h, got %h", name, pend_d[p][rd_delay-1], d);
        note_error();
      end
    end else if (v !== 1'b0) begin
      $display("Port %0d raised rvalid with no read in flight", p + 1);
      note_error();
    end
  endtask

  task automatic close_test(input int tag);
    if (tag != last_tag) begin
      if (last_tag >= 0) begin
        $display("Test %0d %s: %0d reads checked, %0d failed checks", last_tag,
                 (test_errs == 0) ? "passed" : "failed", test_checks, test_errs);
        tests_done = tests_done + 1;
      end
      if (tag == -2 && !done_flag) begin
        $display("%0d tests, %0d reads checked, %0d failed checks", tests_done, checks,
                 err_count + reset_errs);
        done_flag = 1'b1;
      end
      last_tag    = tag;
      test_errs   = 0;
      test_checks = 0;
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n && ((rvalid1 !== 1'b0) || (rvalid2 !== 1'b0))) begin
      $display("rvalid was high while reset was asserted");
      reset_errs = reset_errs + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < rd_delay; i++) begin
        pend_v[0][i] = 1'b0;
        pend_v[1][i] = 1'b0;
        pend_t[i]    = -1;
      end
    end else begin
      close_test(pend_t[rd_delay-1]);
      check_port(0, rvalid1, rdata1);
      check_port(1, rvalid2, rdata2);
      for (int i = rd_delay - 1; i > 0; i--) begin
        for (int p = 0; p < 2; p++) begin
          pend_v[p][i] = pend_v[p][i-1];
          pend_d[p][i] = pend_d[p][i-1];
          pend_k[p][i] = pend_k[p][i-1];
        end
        pend_t[i] = pend_t[i-1];
      end
      // Expected data is taken before this edge's writes land.
      pend_v[0][0] = rd1;
      pend_d[0][0] = ref_mem[rd_bank1][rd_row1];
      pend_k[0][0] = written[rd_bank1][rd_row1];
      pend_v[1][0] = rd2;
      pend_d[1][0] = ref_mem[rd_bank2][rd_row2];
      pend_k[1][0] = written[rd_bank2][rd_row2];
      pend_t[0]    = entry;
      if (wr1) begin
        ref_mem[wr_bank1][wr_row1] = wdata1;
        written[wr_bank1][wr_row1] = 1'b1;
      end
      if (wr2) begin
        ref_mem[wr_bank2][wr_row2] = wdata2;  // Port 2 lands last.
        written[wr_bank2][wr_row2] = 1'b1;
      end
    end
  end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import mp_pkg::*; ();

  localparam int num_tests = 13;
  localparam int rows      = 1 << def_bit_row;

  typedef struct packed {
    logic                    en;
    logic [def_bit_bank-1:0] bank;
    logic [def_bit_row-1:0]  row;
    logic [def_width-1:0]    data;  // Unused on reads.
  } req_t;

  typedef struct packed {
    logic        rnd;  // Requests come from the random generator.
    logic [31:0] count;
    req_t        r1;
    req_t        r2;
    req_t        w1;
    req_t        w2;
  } entry_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    rd1, rd2, wr1, wr2;
  logic [def_bit_bank-1:0] rd_bank1, rd_bank2, wr_bank1, wr_bank2;
  logic [def_bit_row-1:0]  rd_row1, rd_row2, wr_row1, wr_row2;
  logic [def_width-1:0]    wdata1, wdata2;
  logic [def_width-1:0]    rdata1, rdata2;
  logic                    rvalid1, rvalid2;
  int                      entry;
  logic                    finished;
  int                      errors;

  entry_t                  tests [num_tests];
  bit                      cached [def_num_bank][rows];  // Addresses held in the cache.
  bit                      slot_v [rows];
  logic [def_bit_bank-1:0] slot_b [rows];
  int                      seed    = 56;
  int                      cycles  = 0;
  int                      limit   = 0;
  bit                      running = 1'b0;

  mp_top mp_top_inst (.*);

  mp_checker u_check (.*);

  always #50 clk = ~clk;

  function automatic req_t req(input int bank, input int row, input int data);
    req_t r;
    r.en   = 1'b1;
    r.bank = bank[def_bit_bank-1:0];
    r.row  = row[def_bit_row-1:0];
    r.data = data;
    return r;
  endfunction

  function automatic entry_t step(input req_t r1, input req_t r2, input req_t w1,
                                  input req_t w2, input int count);
    entry_t t;
    t.rnd   = 1'b0;
    t.count = count;
    t.r1    = r1;
    t.r2    = r2;
    t.w1    = w1;
    t.w2    = w2;
    return t;
  endfunction

  function automatic void build_tests();
    tests[0]  = step('0, '0, req(1, 3, 32'h1111_0001), req(2, 3, 32'h2222_0002), 1);
    tests[1]  = step(req(1, 3, 0), req(2, 3, 0), '0, '0, 2);
    tests[2]  = step(req(2, 3, 0), req(1, 3, 0), '0, '0, 1);
    tests[3]  = step('0, '0, req(4, 10, 32'hc0de_000a), req(4, 11, 32'hd00d_000b), 1);
    tests[4]  = step(req(4, 11, 0), req(4, 10, 0), '0, '0, 1);
    tests[5]  = step('0, '0, req(5, 11, 32'h5555_0005), '0, 1);  // Same row, other bank.
    tests[6]  = step(req(5, 11, 0), req(4, 11, 0), '0, '0, 1);
    tests[7]  = step('0, '0, req(4, 12, 32'h4444_000c), req(4, 11, 32'h7777_000b), 1);
    tests[8]  = step(req(4, 11, 0), req(4, 12, 0), '0, '0, 1);
    tests[9]  = step('0, '0, req(6, 20, 32'h6666_0001), '0, 1);
    tests[10] = step(req(6, 20, 0), '0, req(6, 20, 32'h6666_0002), '0, 1);
    tests[11] = step('0, req(6, 20, 0), '0, '0, 1);
    tests[12] = '0;
    tests[12].rnd   = 1'b1;
    tests[12].count = 200;
  endfunction

  task automatic random_req(output req_t r);
    logic [31:0] rnd;
    rnd    = $random(seed);
    r.en   = rnd[6];
    r.bank = rnd[2:0];
    r.row  = {3'b100, rnd[5:3]};  // Rows 32 to 39 keep the addresses dense.
    r.data = $random(seed);
  endtask

  // Drops requests that would break the single-slot cache rules.
  task automatic keep_contract(inout req_t w1, inout req_t w2);
    if (w1.en && cached[w1.bank][w1.row]) begin
      w1.en = 1'b0;
    end
    if (w1.en && w2.en && (w1.bank == w2.bank)) begin
      if ((w1.row == w2.row) || (slot_v[w2.row] && (slot_b[w2.row] != w2.bank))) begin
        w2.en = 1'b0;
      end else begin
        slot_v[w2.row]          = 1'b1;
        slot_b[w2.row]          = w2.bank;
        cached[w2.bank][w2.row] = 1'b1;
      end
    end else if (w2.en && cached[w2.bank][w2.row]) begin
      w2.en = 1'b0;
    end
  endtask

  task automatic apply_cycle(input entry_t t, input int idx);
    req_t r1, r2, w1, w2;
    if (t.rnd) begin
      random_req(r1);
      random_req(r2);
      random_req(w1);
      random_req(w2);
    end else begin
      r1 = t.r1;
      r2 = t.r2;
      w1 = t.w1;
      w2 = t.w2;
    end
    keep_contract(w1, w2);
    rd1      <= r1.en;
    rd_bank1 <= r1.bank;
    rd_row1  <= r1.row;
    rd2      <= r2.en;
    rd_bank2 <= r2.bank;
    rd_row2  <= r2.row;
    wr1      <= w1.en;
    wr_bank1 <= w1.bank;
    wr_row1  <= w1.row;
    wdata1   <= w1.data;
    wr2      <= w2.en;
    wr_bank2 <= w2.bank;
    wr_row2  <= w2.row;
    wdata2   <= w2.data;
    entry    <= idx;
  endtask

  always @(posedge clk) begin
    if (running) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("Timeout after %0d cycles, the checker never finished", cycles);
        $display("Errors found");
        $finish;
      end
    end
  end

  initial begin
    rst_n    = 1'b0;
    rd1      = 1'b0;
    rd_bank1 = '0;
    rd_row1  = '0;
    rd2      = 1'b0;
    rd_bank2 = '0;
    rd_row2  = '0;
    wr1      = 1'b0;
    wr_bank1 = '0;
    wr_row1  = '0;
    wdata1   = '0;
    wr2      = 1'b0;
    wr_bank2 = '0;
    wr_row2  = '0;
    wdata2   = '0;
    entry    = -1;
    build_tests();
    limit = def_rd_delay + 20;
    for (int e = 0; e < num_tests; e++) begin
      limit = limit + int'(tests[e].count);
    end
    repeat (10) @(posedge clk);
    rst_n   <= 1'b1;
    running <= 1'b1;
    for (int e = 0; e < num_tests; e++) begin
      for (int n = 0; n < int'(tests[e].count); n++) begin
        @(posedge clk);
        apply_cycle(tests[e], e);
      end
    end
    @(posedge clk);
    apply_cycle('0, -2);  // End marker for the checker.
    while (finished !== 1'b1) @(negedge clk);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* list.f */
source/mp_pkg.sv
source/bank_if.sv
source/table_if.sv
source/mp_port_mux.sv
source/mp_ctrl.sv
source/bank_array.sv
source/dual_table.sv
source/mp_top.sv
tests/mp_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
